//--- Bender.yml
package:
  name: mini_core

sources:
  - target: any(rtl, test)
    files:
      - logic/miniCorePkg.sv
      - logic/miniCoreFetch.sv
      - logic/miniCoreCtrl.sv
      - logic/miniCoreRegFile.sv
      - logic/miniCoreExecute.sv
      - logic/miniCoreMemWb.sv
      - logic/miniCore.sv
  - target: test
    files:
      - testbench/miniCoreTb.sv

//--- logic/miniCore.sv
`timescale 1ns/100ps

module miniCore
    import miniCorePkg::*;
#(
    parameter int ImemWords = 256
) (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         imemWrEn,   // Program load, used in reset
    input  logic [$clog2(ImemWords)-1:0] imemWrAddr,
    input  logic [31:0]                  imemWrData,
    input  logic [31:0]                  dMemRdData,
    input  logic                         dMemReady,  // Low freezes the pipe
    output logic                         dMemRdEn,
    output logic                         dMemWrEn,
    output logic [31:0]                  dMemAddr,
    output logic [31:0]                  dMemWrData,
    output logic [3:0]                   dMemByteEn
);

// Stage enables
logic        readyQ100, readyQ101, readyQ102, readyQ103, readyQ104;

// Fetch and decode
logic [31:0] preInstructionQ101, pcQ101, immediateQ101;
logic [4:0]  regSrc1Q101, regSrc2Q101;
logic [31:0] regData1Q101, regData2Q101;

// Execute
logic [31:0] pcQ102, aluOutQ102;
t_aluOp      aluOpQ102;
t_branchType branchOpQ102;
logic        luiQ102, selAluPcQ102, selAluImmQ102, selNextPcAluOutBQ102;
logic        branchCondMetQ102, selNextPcAluOutQ102;
logic [4:0]  regSrc1Q102, regSrc2Q102;

// Memory and write-back
logic [31:0] pcQ103, aluOutQ103, storeDataQ103;
logic [4:0]  regDstQ103, regDstQ104;
logic        regWrEnQ103, dMemRdEnQ103, dMemWrEnQ103;
logic [3:0]  dMemByteEnQ103, byteEnQ104;
logic        regWrEnQ104, signExtQ104;
t_wbSel      wbSelQ104;
logic [31:0] wbDataQ104;

// Port names match across the core
miniCoreFetch #(
    .ImemWords(ImemWords)
) fetch_i (.*);

miniCoreCtrl    ctrl_i    (.*);
miniCoreRegFile regFile_i (.*);
miniCoreExecute execute_i (.*);
miniCoreMemWb   memWb_i   (.*);

endmodule

//--- logic/miniCoreCtrl.sv
`timescale 1ns/100ps

module miniCoreCtrl
    import miniCorePkg::*;
(
    input  logic        Clock,
    input  logic        rstN,
    input  logic [31:0] preInstructionQ101,
    input  logic [31:0] pcQ101,
    input  logic        branchCondMetQ102,   // Already qualified by branch opcode
    input  logic        dMemReady,
    output logic        readyQ100,
    output logic        readyQ101,
    output logic        readyQ102,
    output logic        readyQ103,
    output logic        readyQ104,
    output logic        selNextPcAluOutQ102,
    output logic [31:0] immediateQ101,
    output logic [4:0]  regSrc1Q101,
    output logic [4:0]  regSrc2Q101,
    // Execute control
    output logic [31:0] pcQ102,
    output t_aluOp      aluOpQ102,
    output logic        luiQ102,
    output t_branchType branchOpQ102,
    output logic        selAluPcQ102,
    output logic        selAluImmQ102,
    output logic        selNextPcAluOutBQ102,
    output logic [4:0]  regSrc1Q102,
    output logic [4:0]  regSrc2Q102,
    // Memory stage control
    output logic [31:0] pcQ103,
    output logic [4:0]  regDstQ103,
    output logic        regWrEnQ103,
    output logic        dMemRdEnQ103,
    output logic        dMemWrEnQ103,
    output logic [3:0]  dMemByteEnQ103,
    // Write-back control
    output logic [4:0]  regDstQ104,
    output logic        regWrEnQ104,
    output logic        signExtQ104,
    output logic [3:0]  byteEnQ104,
    output t_wbSel      wbSelQ104
);

logic        coreFreeze;
logic        loadHazardQ101;
logic        flushQ102;
logic        flushQ103;
logic        killQ101;
logic        validQ101;
logic [31:0] instructionQ101;
t_opcode     opcodeQ101;
logic [2:0]  funct3Q101;
logic [6:0]  funct7Q101;
t_immediate  immTypeQ101;
t_aluOp      aluOpQ101;
logic [3:0]  byteEnQ101;
t_wbSel      wbSelQ101;
logic        jumpQ102;
logic [4:0]  regDstQ102;
logic        regWrEnQ102, dMemRdEnQ102, dMemWrEnQ102, signExtQ102;
logic [3:0]  byteEnQ102;
t_wbSel      wbSelQ102;
logic        rawRegWrEnQ103, rawDMemRdEnQ103, rawDMemWrEnQ103, signExtQ103;
t_wbSel      wbSelQ103;
logic        rawRegWrEnQ104;
logic        validQ102, validQ103, validQ104;

// ----------------------------------------
// Hazards and flush
// ----------------------------------------
// Load in Q102 feeding the word in Q101
assign loadHazardQ101 = validQ102 && dMemRdEnQ102 && (regDstQ102 != 5'd0) &&
                        ((preInstructionQ101[19:15] == regDstQ102) ||
                         (preInstructionQ101[24:20] == regDstQ102));

assign selNextPcAluOutQ102 = validQ102 && (jumpQ102 || branchCondMetQ102);
assign flushQ102           = selNextPcAluOutQ102; // Two younger words are dead
assign killQ101            = flushQ102 || flushQ103 || loadHazardQ101;
assign instructionQ101     = killQ101 ? NOP : preInstructionQ101;
assign validQ101           = readyQ101 && !killQ101;

// ----------------------------------------
// Decode in Q101
// ----------------------------------------
assign opcodeQ101  = t_opcode'(instructionQ101[6:0]);
assign funct3Q101  = instructionQ101[14:12];
assign funct7Q101  = instructionQ101[31:25];
assign regSrc1Q101 = instructionQ101[19:15];
assign regSrc2Q101 = instructionQ101[24:20];

always_comb begin
    aluOpQ101 = ADD; // Address and target math
    if ((opcodeQ101 == R_OP) || (opcodeQ101 == I_OP)) begin
        case (funct3Q101)
            3'b000:  aluOpQ101 = ((opcodeQ101 == R_OP) && funct7Q101[5]) ? SUB : ADD;
            3'b001:  aluOpQ101 = SLL;
            3'b010:  aluOpQ101 = SLT;
            3'b011:  aluOpQ101 = SLTU;
            3'b100:  aluOpQ101 = XOR;
            3'b101:  aluOpQ101 = funct7Q101[5] ? SRA : SRL; // SRAI too
            3'b110:  aluOpQ101 = OR;
            default: aluOpQ101 = AND;
        endcase
    end
end

// Access size, zero for non-memory ops
always_comb begin
    byteEnQ101 = 4'b0000;
    if ((opcodeQ101 == LOAD) || (opcodeQ101 == STORE)) begin
        case (funct3Q101[1:0])
            2'b00:   byteEnQ101 = 4'b0001;
            2'b01:   byteEnQ101 = 4'b0011;
            2'b10:   byteEnQ101 = 4'b1111;
            default: byteEnQ101 = 4'b0000;
        endcase
    end
end

assign wbSelQ101 = ((opcodeQ101 == JAL) || (opcodeQ101 == JALR)) ? WB_PC4  :
                   (opcodeQ101 == LOAD)                          ? WB_DMEM :
                                                                   WB_ALU;

// Immediate format, then the value
always_comb begin
    case (opcodeQ101)
        LUI, AUIPC: immTypeQ101 = U_TYPE;
        JAL:        immTypeQ101 = J_TYPE;
        BRANCH:     immTypeQ101 = B_TYPE;
        STORE:      immTypeQ101 = S_TYPE;
        default:    immTypeQ101 = I_TYPE; // JALR, LOAD, I_OP
    endcase
    case (immTypeQ101)
        U_TYPE:  immediateQ101 = {instructionQ101[31:12], 12'b0};
        S_TYPE:  immediateQ101 = {{20{instructionQ101[31]}}, instructionQ101[31:25],
                                  instructionQ101[11:7]};
        B_TYPE:  immediateQ101 = {{20{instructionQ101[31]}}, instructionQ101[7],
                                  instructionQ101[30:25], instructionQ101[11:8], 1'b0};
        J_TYPE:  immediateQ101 = {{12{instructionQ101[31]}}, instructionQ101[19:12],
                                  instructionQ101[20], instructionQ101[30:21], 1'b0};
        default: immediateQ101 = {{20{instructionQ101[31]}}, instructionQ101[31:20]};
    endcase
end

// ----------------------------------------
// Back-pressure
// ----------------------------------------
assign coreFreeze = !dMemReady; // Memory not done, whole pipe holds
assign readyQ104  = !coreFreeze;
assign readyQ103  = !coreFreeze;
assign readyQ102  = !coreFreeze;
assign readyQ101  = !coreFreeze && !loadHazardQ101; // Bubble goes to Q102
assign readyQ100  = readyQ101;

// ----------------------------------------
// Control pipe
// ----------------------------------------
always_ff @(posedge Clock) begin
    if (readyQ102) begin
        pcQ102               <= pcQ101;
        aluOpQ102            <= aluOpQ101;
        luiQ102              <= (opcodeQ101 == LUI);
        branchOpQ102         <= t_branchType'(funct3Q101);
        selAluPcQ102         <= (opcodeQ101 == JAL) || (opcodeQ101 == BRANCH) ||
                                (opcodeQ101 == AUIPC);
        selAluImmQ102        <= (opcodeQ101 != R_OP); // Only reg-reg uses rs2
        selNextPcAluOutBQ102 <= (opcodeQ101 == BRANCH);
        jumpQ102             <= (opcodeQ101 == JAL) || (opcodeQ101 == JALR);
        regSrc1Q102          <= regSrc1Q101;
        regSrc2Q102          <= regSrc2Q101;
        regDstQ102           <= instructionQ101[11:7];
        regWrEnQ102          <= (opcodeQ101 == LUI)  || (opcodeQ101 == AUIPC) ||
                                (opcodeQ101 == JAL)  || (opcodeQ101 == JALR)  ||
                                (opcodeQ101 == LOAD) || (opcodeQ101 == I_OP)  ||
                                (opcodeQ101 == R_OP) || (opcodeQ101 == FENCE);
        dMemRdEnQ102         <= (opcodeQ101 == LOAD);
        dMemWrEnQ102         <= (opcodeQ101 == STORE);
        signExtQ102          <= !funct3Q101[2]; // LB/LH, not LBU/LHU
        byteEnQ102           <= byteEnQ101;
        wbSelQ102            <= wbSelQ101;
    end
    if (readyQ103) begin
        pcQ103          <= pcQ102;
        regDstQ103      <= regDstQ102;
        rawRegWrEnQ103  <= regWrEnQ102;
        rawDMemRdEnQ103 <= dMemRdEnQ102;
        rawDMemWrEnQ103 <= dMemWrEnQ102;
        dMemByteEnQ103  <= byteEnQ102;
        signExtQ103     <= signExtQ102;
        wbSelQ103       <= wbSelQ102;
    end
    if (readyQ104) begin
        regDstQ104     <= regDstQ103;
        rawRegWrEnQ104 <= rawRegWrEnQ103;
        signExtQ104    <= signExtQ103;
        byteEnQ104     <= dMemByteEnQ103;
        wbSelQ104      <= wbSelQ103;
    end
end

// Valid bits and flush shadow
always_ff @(posedge Clock) begin
    if (!rstN) begin
        validQ102 <= 1'b0;
        validQ103 <= 1'b0;
        validQ104 <= 1'b0;
        flushQ103 <= 1'b0;
    end else begin
        if (readyQ102) begin
            validQ102 <= validQ101;
        end
        if (readyQ103) begin
            validQ103 <= validQ102;
            flushQ103 <= flushQ102;
        end
        if (readyQ104) begin
            validQ104 <= validQ103;
        end
    end
end

// Bubbles never touch memory or registers
assign regWrEnQ103  = validQ103 && rawRegWrEnQ103;
assign dMemRdEnQ103 = validQ103 && rawDMemRdEnQ103;
assign dMemWrEnQ103 = validQ103 && rawDMemWrEnQ103;
assign regWrEnQ104  = validQ104 && readyQ104 && rawRegWrEnQ104; // Write once, on release

endmodule

//--- logic/miniCoreExecute.sv
`timescale 1ns/100ps

module miniCoreExecute
    import miniCorePkg::*;
(
    input  logic        Clock,
    input  logic        rstN,
    input  logic        readyQ102,
    input  logic        readyQ103,
    input  logic [31:0] regData1Q101,
    input  logic [31:0] regData2Q101,
    input  logic [31:0] immediateQ101,
    input  logic [31:0] pcQ102,
    input  t_aluOp      aluOpQ102,
    input  logic        luiQ102,
    input  t_branchType branchOpQ102,
    input  logic        selAluPcQ102,
    input  logic        selAluImmQ102,
    input  logic        selNextPcAluOutBQ102,
    input  logic [4:0]  regSrc1Q102,
    input  logic [4:0]  regSrc2Q102,
    input  logic [4:0]  regDstQ103,
    input  logic        regWrEnQ103,
    input  logic [4:0]  regDstQ104,
    input  logic        regWrEnQ104,
    input  logic [31:0] wbDataQ104,
    output logic [31:0] aluOutQ102,
    output logic        branchCondMetQ102,
    output logic [31:0] aluOutQ103,
    output logic [31:0] storeDataQ103
);

logic [31:0] regData1Q102, regData2Q102, immediateQ102;
logic [31:0] src1Q102, src2Q102;
logic [31:0] aluIn1Q102, aluIn2Q102;
logic        condQ102;

always_ff @(posedge Clock) begin
    if (readyQ102) begin
        regData1Q102  <= regData1Q101;
        regData2Q102  <= regData2Q101;
        immediateQ102 <= immediateQ101;
    end
end

// ----------------------------------------
// Forwarding, youngest producer first
// ----------------------------------------
assign src1Q102 = (regWrEnQ103 && (regDstQ103 != 5'd0) && (regDstQ103 == regSrc1Q102)) ?
                  aluOutQ103 :
                  (regWrEnQ104 && (regDstQ104 != 5'd0) && (regDstQ104 == regSrc1Q102)) ?
                  wbDataQ104 : regData1Q102;
assign src2Q102 = (regWrEnQ103 && (regDstQ103 != 5'd0) && (regDstQ103 == regSrc2Q102)) ?
                  aluOutQ103 :
                  (regWrEnQ104 && (regDstQ104 != 5'd0) && (regDstQ104 == regSrc2Q102)) ?
                  wbDataQ104 : regData2Q102;

assign aluIn1Q102 = selAluPcQ102  ? pcQ102        : src1Q102; // JAL, branch, AUIPC
assign aluIn2Q102 = selAluImmQ102 ? immediateQ102 : src2Q102;

// ALU
always_comb begin
    case (aluOpQ102)
        SUB:     aluOutQ102 = aluIn1Q102 - aluIn2Q102;
        SLL:     aluOutQ102 = aluIn1Q102 << aluIn2Q102[4:0];
        SLT:     aluOutQ102 = {31'b0, $signed(aluIn1Q102) < $signed(aluIn2Q102)};
        SLTU:    aluOutQ102 = {31'b0, aluIn1Q102 < aluIn2Q102};
        XOR:     aluOutQ102 = aluIn1Q102 ^ aluIn2Q102;
        SRL:     aluOutQ102 = aluIn1Q102 >> aluIn2Q102[4:0];
        SRA:     aluOutQ102 = $signed(aluIn1Q102) >>> aluIn2Q102[4:0];
        OR:      aluOutQ102 = aluIn1Q102 | aluIn2Q102;
        AND:     aluOutQ102 = aluIn1Q102 & aluIn2Q102;
        default: aluOutQ102 = aluIn1Q102 + aluIn2Q102;
    endcase
    if (luiQ102) begin
        aluOutQ102 = immediateQ102; // Upper immediate as is
    end
end

// Branch compare on forwarded operands
always_comb begin
    case (branchOpQ102)
        BEQ:     condQ102 = (src1Q102 == src2Q102);
        BNE:     condQ102 = (src1Q102 != src2Q102);
        BLT:     condQ102 = ($signed(src1Q102) <  $signed(src2Q102));
        BGE:     condQ102 = ($signed(src1Q102) >= $signed(src2Q102));
        BLTU:    condQ102 = (src1Q102 <  src2Q102);
        BGEU:    condQ102 = (src1Q102 >= src2Q102);
        default: condQ102 = 1'b0;
    endcase
end

assign branchCondMetQ102 = selNextPcAluOutBQ102 && condQ102;

// Result and store data into Q103
always_ff @(posedge Clock) begin
    if (!rstN) begin
        aluOutQ103    <= '0; // Quiet bus address out of reset
        storeDataQ103 <= '0;
    end else if (readyQ103) begin
        aluOutQ103    <= aluOutQ102;
        storeDataQ103 <= src2Q102;
    end
end

endmodule

//--- logic/miniCoreFetch.sv
`timescale 1ns/100ps

module miniCoreFetch
    import miniCorePkg::*;
#(
    parameter  int ImemWords = 256,
    localparam int ImemAddrW = $clog2(ImemWords)
) (
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 readyQ100,
    input  logic                 selNextPcAluOutQ102, // Taken branch or jump
    input  logic [31:0]          aluOutQ102,          // Redirect target
    input  logic                 imemWrEn,
    input  logic [ImemAddrW-1:0] imemWrAddr,
    input  logic [31:0]          imemWrData,
    output logic [31:0]          preInstructionQ101,
    output logic [31:0]          pcQ101
);

logic [31:0] imem [ImemWords];
logic [31:0] pcQ100;
logic [31:0] nextPcQ100;

// Target wins over sequential fetch
assign nextPcQ100 = selNextPcAluOutQ102 ? aluOutQ102 : pcQ100 + 32'd4;

// Program load port
always_ff @(posedge Clock) begin
    if (imemWrEn) begin
        imem[imemWrAddr] <= imemWrData;
    end
end

// PC and registered instruction read
always_ff @(posedge Clock) begin
    if (!rstN) begin
        pcQ100             <= '0;
        pcQ101             <= '0;
        preInstructionQ101 <= NOP; // Harmless word until first fetch
    end else if (readyQ100) begin
        pcQ100             <= nextPcQ100;
        pcQ101             <= pcQ100;
        preInstructionQ101 <= imem[pcQ100[ImemAddrW+1:2]]; // Word addressed
    end
end

endmodule

//--- logic/miniCoreMemWb.sv
`timescale 1ns/100ps

module miniCoreMemWb
    import miniCorePkg::*;
(
    input  logic        Clock,
    input  logic        rstN,
    input  logic        readyQ104,
    input  logic [31:0] pcQ103,
    input  logic [31:0] aluOutQ103,
    input  logic [31:0] storeDataQ103,
    input  logic        dMemRdEnQ103,
    input  logic        dMemWrEnQ103,
    input  logic [3:0]  dMemByteEnQ103,
    input  logic        signExtQ104,
    input  logic [3:0]  byteEnQ104,
    input  t_wbSel      wbSelQ104,
    input  logic [31:0] dMemRdData,
    output logic        dMemRdEn,
    output logic        dMemWrEn,
    output logic [31:0] dMemAddr,
    output logic [31:0] dMemWrData,
    output logic [3:0]  dMemByteEn,
    output logic [31:0] wbDataQ104
);

logic [1:0]  offsetQ103;
logic [1:0]  offsetQ104;
logic [31:0] aluOutQ104, pc4Q104, rdDataQ104;
logic [31:0] shiftedQ104;
logic [31:0] loadDataQ104;

// ----------------------------------------
// Q103 bus drive
// ----------------------------------------
assign offsetQ103 = aluOutQ103[1:0];
assign dMemRdEn   = dMemRdEnQ103;
assign dMemWrEn   = dMemWrEnQ103;
assign dMemAddr   = aluOutQ103;
assign dMemWrData = storeDataQ103 << {offsetQ103, 3'b000}; // Move into byte lane
assign dMemByteEn = dMemByteEnQ103 << offsetQ103;

// Sampled on the edge that completes the access
always_ff @(posedge Clock) begin
    if (!rstN) begin
        aluOutQ104 <= '0;
        pc4Q104    <= '0;
        offsetQ104 <= '0;
        rdDataQ104 <= '0;
    end else if (readyQ104) begin
        aluOutQ104 <= aluOutQ103;
        pc4Q104    <= pcQ103 + 32'd4; // Link value
        offsetQ104 <= offsetQ103;
        rdDataQ104 <= dMemRdData;
    end
end

// ----------------------------------------
// Q104 load format and write-back
// ----------------------------------------
assign shiftedQ104 = rdDataQ104 >> {offsetQ104, 3'b000}; // Lane down to bit 0

always_comb begin
    case (byteEnQ104)
        4'b0001: loadDataQ104 = {{24{signExtQ104 && shiftedQ104[7]}}, shiftedQ104[7:0]};
        4'b0011: loadDataQ104 = {{16{signExtQ104 && shiftedQ104[15]}}, shiftedQ104[15:0]};
        default: loadDataQ104 = shiftedQ104; // Word
    endcase
end

always_comb begin
    case (wbSelQ104)
        WB_DMEM: wbDataQ104 = loadDataQ104;
        WB_PC4:  wbDataQ104 = pc4Q104;
        default: wbDataQ104 = aluOutQ104;
    endcase
end

endmodule

//--- logic/miniCorePkg.sv
package miniCorePkg;

    // ----------------------------------------
    // RV32I major opcodes, bits [6:0]
    // ----------------------------------------
    typedef enum logic [6:0] {
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        I_OP   = 7'b0010011,
        R_OP   = 7'b0110011,
        FENCE  = 7'b0001111,
        SYSTEM = 7'b1110011  // Decoded as a plain no-op here
    } t_opcode;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } t_aluOp;

    // Branch condition, taken straight from funct3
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } t_branchType;

    typedef enum logic [2:0] {
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } t_immediate;

    // Write-back source in Q104
    typedef enum logic [1:0] {
        WB_ALU,
        WB_DMEM,
        WB_PC4
    } t_wbSel;

    localparam logic [31:0] NOP = 32'h0000_0013; // addi x0,x0,0

endpackage

//--- logic/miniCoreRegFile.sv
`timescale 1ns/100ps

module miniCoreRegFile (
    input  logic        Clock,
    input  logic        rstN,
    input  logic [4:0]  regSrc1Q101,
    input  logic [4:0]  regSrc2Q101,
    input  logic        regWrEnQ104,
    input  logic [4:0]  regDstQ104,
    input  logic [31:0] wbDataQ104,
    output logic [31:0] regData1Q101,
    output logic [31:0] regData2Q101
);

logic [31:0] regs [1:31]; // x0 has no storage
logic        wrActive;

assign wrActive = regWrEnQ104 && (regDstQ104 != 5'd0);

always_ff @(posedge Clock) begin
    if (!rstN) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (wrActive) begin
        regs[regDstQ104] <= wbDataQ104;
    end
end

// x0 first, then write-through, then array
assign regData1Q101 = (regSrc1Q101 == 5'd0)                   ? '0         :
                      (wrActive && (regDstQ104 == regSrc1Q101)) ? wbDataQ104 : regs[regSrc1Q101];
assign regData2Q101 = (regSrc2Q101 == 5'd0)                   ? '0         :
                      (wrActive && (regDstQ104 == regSrc2Q101)) ? wbDataQ104 : regs[regSrc2Q101];

endmodule

//--- sim.f
logic/miniCorePkg.sv
logic/miniCoreFetch.sv
logic/miniCoreCtrl.sv
logic/miniCoreRegFile.sv
logic/miniCoreExecute.sv
logic/miniCoreMemWb.sv
logic/miniCore.sv
testbench/miniCoreTb.sv

//--- testbench/miniCoreTb.sv
`timescale 1ns/100ps

module miniCoreTb;

localparam int ImemWords    = 256;
localparam int RunTimeout   = 3000; // Cycles allowed for one program run
localparam int SettleCycles = 40;   // Quiet window for late extra stores

// RV32I opcodes used by the assembler functions
localparam logic [6:0] OpLui   = 7'b0110111;
localparam logic [6:0] OpAuipc = 7'b0010111;
localparam logic [6:0] OpJalr  = 7'b1100111;
localparam logic [6:0] OpLoad  = 7'b0000011;
localparam logic [6:0] OpImm   = 7'b0010011;

logic        Clock;
logic        rstN;
logic        imemWrEn;
logic [7:0]  imemWrAddr;
logic [31:0] imemWrData;
logic [31:0] dMemRdData;
logic        dMemReady;
logic        dMemRdEn;
logic        dMemWrEn;
logic [31:0] dMemAddr;
logic [31:0] dMemWrData;
logic [3:0]  dMemByteEn;

logic [31:0] dataMem [64];     // Byte-enabled data memory model
logic [31:0] prog [$];         // Program words, address 0 upward
logic [31:0] expAddr [$];      // Expected stores, in program order
logic [3:0]  expBe [$];
logic [31:0] expData [$];      // Lane positioned, zero outside enables
int          nextStore;        // Queue head
int          errors;
int          checks;
integer      seed;
logic        randomReady;
logic        heldWrite;        // Store was stalled at the last edge
logic [31:0] heldAddr;
logic [31:0] heldData;
logic [3:0]  heldBe;

miniCore #(
    .ImemWords(ImemWords)
) dut_i (.*);

always #50 Clock = ~Clock;

// ----------------------------------------
// Instruction formats
// ----------------------------------------
function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] iTypeWord(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sTypeWord(input logic [2:0] f3, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] bTypeWord(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] uTypeWord(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] upper);
    return {upper, rd, op};
endfunction

function automatic logic [31:0] jTypeWord(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// Store off base x1 (0x40) that must reach the bus
task addStore(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] offset,
              input logic [3:0] be, input logic [31:0] data);
    prog.push_back(sTypeWord(f3, rs2, 5'd1, offset));
    expAddr.push_back(32'h40 + offset);
    expBe.push_back(be);
    expData.push_back(data);
endtask

task buildProgram;
    prog.push_back(iTypeWord(OpImm, 5'd1, 3'b000, 5'd0, 12'd64));       // x1 = 0x40
    prog.push_back(iTypeWord(OpImm, 5'd2, 3'b000, 5'd0, 12'hFFB));      // x2 = -5
    addStore(3'b010, 5'd2, 12'd0, 4'hF, 32'hFFFF_FFFB);
    prog.push_back(iTypeWord(OpImm, 5'd3, 3'b000, 5'd0, 12'd12));       // x3 = 12
    prog.push_back(rTypeWord(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));         // sub 12 - -5
    addStore(3'b010, 5'd4, 12'd4, 4'hF, 32'h0000_0011);
    prog.push_back(iTypeWord(OpImm, 5'd5, 3'b001, 5'd3, 12'd4));        // slli
    addStore(3'b010, 5'd5, 12'd8, 4'hF, 32'h0000_00C0);
    prog.push_back(iTypeWord(OpImm, 5'd6, 3'b101, 5'd2, 12'h401));      // srai by 1
    prog.push_back(iTypeWord(OpImm, 5'd7, 3'b101, 5'd2, 12'd28));       // srli by 28
    addStore(3'b010, 5'd6, 12'd12, 4'hF, 32'hFFFF_FFFD);
    addStore(3'b010, 5'd7, 12'd16, 4'hF, 32'h0000_000F);
    prog.push_back(rTypeWord(7'h00, 3'b010, 5'd8, 5'd2, 5'd3));         // slt, signed true
    prog.push_back(rTypeWord(7'h00, 3'b011, 5'd9, 5'd2, 5'd3));         // sltu, false
    addStore(3'b010, 5'd8, 12'd20, 4'hF, 32'h0000_0001);
    addStore(3'b010, 5'd9, 12'd24, 4'hF, 32'h0000_0000);
    prog.push_back(rTypeWord(7'h00, 3'b100, 5'd11, 5'd2, 5'd3));        // xor
    addStore(3'b010, 5'd11, 12'd28, 4'hF, 32'hFFFF_FFF7);
    prog.push_back(uTypeWord(OpLui, 5'd12, 20'h12345));
    addStore(3'b010, 5'd12, 12'd32, 4'hF, 32'h1234_5000);
    prog.push_back(uTypeWord(OpAuipc, 5'd13, 20'h00001));               // At 0x50
    addStore(3'b010, 5'd13, 12'd36, 4'hF, 32'h0000_1050);
    prog.push_back(rTypeWord(7'h20, 3'b101, 5'd14, 5'd2, 5'd3));        // sra by 12
    addStore(3'b010, 5'd14, 12'd40, 4'hF, 32'hFFFF_FFFF);
    prog.push_back(iTypeWord(OpImm, 5'd15, 3'b111, 5'd11, 12'h0F0));    // andi
    prog.push_back(rTypeWord(7'h00, 3'b110, 5'd15, 5'd15, 5'd3));       // or
    addStore(3'b010, 5'd15, 12'd44, 4'hF, 32'h0000_00FC);
    // Load-use on rs1, then on store data
    prog.push_back(iTypeWord(OpLoad, 5'd16, 3'b010, 5'd1, 12'd4));
    prog.push_back(iTypeWord(OpImm, 5'd17, 3'b000, 5'd16, 12'd100));
    addStore(3'b010, 5'd17, 12'd48, 4'hF, 32'h0000_0075);
    prog.push_back(iTypeWord(OpLoad, 5'd18, 3'b010, 5'd1, 12'd0));
    addStore(3'b010, 5'd18, 12'd52, 4'hF, 32'hFFFF_FFFB);
    // Taken beq at 0x80 skips two stores
    prog.push_back(bTypeWord(3'b000, 5'd3, 5'd3, 13'd12));
    prog.push_back(sTypeWord(3'b010, 5'd3, 5'd1, 12'd56));
    prog.push_back(sTypeWord(3'b010, 5'd3, 5'd1, 12'd60));
    prog.push_back(bTypeWord(3'b001, 5'd3, 5'd3, 13'd12));              // bne falls through
    addStore(3'b010, 5'd3, 12'd56, 4'hF, 32'h0000_000C);
    addStore(3'b010, 5'd8, 12'd60, 4'hF, 32'h0000_0001);
    prog.push_back(iTypeWord(OpImm, 5'd19, 3'b000, 5'd0, 12'd168));
    prog.push_back(iTypeWord(OpJalr, 5'd0, 3'b000, 5'd19, 12'd0));     // To 0xA8
    prog.push_back(sTypeWord(3'b010, 5'd2, 5'd1, 12'd56));
    prog.push_back(sTypeWord(3'b010, 5'd2, 5'd1, 12'd60));
    prog.push_back(jTypeWord(5'd20, 21'd12));                           // jal at 0xA8
    prog.push_back(sTypeWord(3'b010, 5'd2, 5'd1, 12'd0));
    prog.push_back(sTypeWord(3'b010, 5'd2, 5'd1, 12'd4));
    addStore(3'b010, 5'd20, 12'd64, 4'hF, 32'h0000_00AC);               // Link value
    // Sub-word stores and reloads on the word at 0x84
    prog.push_back(uTypeWord(OpLui, 5'd21, 20'h89ABD));
    prog.push_back(iTypeWord(OpImm, 5'd21, 3'b000, 5'd21, 12'hDEF));    // 0x89ABCDEF
    addStore(3'b000, 5'd21, 12'd69, 4'b0010, 32'h0000_EF00);
    addStore(3'b001, 5'd21, 12'd70, 4'b1100, 32'hCDEF_0000);
    addStore(3'b000, 5'd21, 12'd68, 4'b0001, 32'h0000_00EF);
    prog.push_back(iTypeWord(OpLoad, 5'd22, 3'b000, 5'd1, 12'd69));     // lb
    prog.push_back(iTypeWord(OpLoad, 5'd23, 3'b100, 5'd1, 12'd69));     // lbu
    prog.push_back(iTypeWord(OpLoad, 5'd24, 3'b001, 5'd1, 12'd70));     // lh
    addStore(3'b010, 5'd22, 12'd72, 4'hF, 32'hFFFF_FFEF);
    addStore(3'b010, 5'd23, 12'd76, 4'hF, 32'h0000_00EF);
    addStore(3'b010, 5'd24, 12'd80, 4'hF, 32'hFFFF_CDEF);
    prog.push_back(iTypeWord(OpLoad, 5'd25, 3'b010, 5'd1, 12'd68));
    addStore(3'b010, 5'd25, 12'd84, 4'hF, 32'hCDEF_EFEF);
    prog.push_back(jTypeWord(5'd0, 21'd0));                             // Park here
    prog.push_back(iTypeWord(OpImm, 5'd0, 3'b000, 5'd0, 12'd0));
    prog.push_back(iTypeWord(OpImm, 5'd0, 3'b000, 5'd0, 12'd0));
endtask

// ----------------------------------------
// Data memory model
// ----------------------------------------
// Poison word unless a read is requested
assign dMemRdData = dMemRdEn ? dataMem[dMemAddr[7:2]] : 32'hBAD0_BAD0;

always @(posedge Clock) begin
    if (dMemWrEn && dMemReady) begin
        for (int b = 0; b < 4; b++) begin
            if (dMemByteEn[b]) begin
                dataMem[dMemAddr[7:2]][8*b +: 8] <= dMemWrData[8*b +: 8];
            end
        end
    end
end

// Wait states, 1 in 4 cycles on average
always @(posedge Clock) begin
    #1;
    dMemReady = randomReady ? (($random(seed) & 3) != 0) : 1'b1;
end

// ----------------------------------------
// Bus checks
// ----------------------------------------
task checkStore;
    logic [31:0] mask;
    if (nextStore >= expAddr.size()) begin
        errors++;
        $display("extra store to address %h after the expected list", dMemAddr);
    end else begin
        mask = {{8{expBe[nextStore][3]}}, {8{expBe[nextStore][2]}},
                {8{expBe[nextStore][1]}}, {8{expBe[nextStore][0]}}};
        checks += 3;
        assert (dMemAddr == expAddr[nextStore]) else begin
            errors++;
            $display("mismatch dMemAddr: got %h, expected %h", dMemAddr, expAddr[nextStore]);
        end
        assert (dMemByteEn == expBe[nextStore]) else begin
            errors++;
            $display("mismatch dMemByteEn: got %h, expected %h", dMemByteEn,
                     expBe[nextStore]);
        end
        assert ((dMemWrData & mask) == expData[nextStore]) else begin
            errors++;
            $display("mismatch dMemWrData: got %h, expected %h", dMemWrData & mask,
                     expData[nextStore]);
        end
        nextStore++;
    end
endtask

always @(posedge Clock) begin
    if (rstN) begin
        if (heldWrite) begin
            checks++;
            assert (dMemWrEn && (dMemAddr == heldAddr) && (dMemWrData == heldData) &&
                    (dMemByteEn == heldBe)) else begin
                errors++;
                $display("store to %h changed while dMemReady was low", heldAddr);
            end
        end
        checks++;
        assert (!(dMemRdEn && dMemWrEn)) else begin
            errors++;
            $display("read and write requested in the same cycle at %h", dMemAddr);
        end
        if (dMemWrEn && dMemReady) begin
            checkStore();
        end
    end
    heldWrite <= rstN && dMemWrEn && !dMemReady;
    heldAddr  <= dMemAddr;
    heldData  <= dMemWrData;
    heldBe    <= dMemByteEn;
end

// ----------------------------------------
// Sequence
// ----------------------------------------
task loadProgram;
    foreach (prog[i]) begin
        @(posedge Clock);
        #1;
        imemWrEn   = 1'b1;
        imemWrAddr = 8'(i);
        imemWrData = prog[i];
    end
    @(posedge Clock);
    #1;
    imemWrEn = 1'b0;
endtask

task applyReset;
    @(posedge Clock);
    #1;
    rstN = 1'b0;
    repeat (16) @(posedge Clock);
    #1;
    rstN = 1'b1;
endtask

task runProgram(input logic withWaits);
    int cycles;
    randomReady = 1'b0;
    for (int i = 0; i < 64; i++) begin
        dataMem[i] = 32'hD0D0_0000 + (i * 4); // Byte address in the low half
    end
    nextStore = 0;
    applyReset();
    randomReady = withWaits;
    cycles = 0;
    while ((nextStore < expAddr.size()) && (cycles < RunTimeout)) begin
        @(posedge Clock);
        #1;
        cycles++;
    end
    if (nextStore < expAddr.size()) begin
        errors++;
        $display("timeout after %0d cycles with %0d of %0d stores seen", cycles, nextStore,
                 expAddr.size());
    end
    repeat (SettleCycles) @(posedge Clock); // Extra stores show up in the checker
    #1;
    $display("run with wait states %0d finished after %0d cycles", withWaits, cycles);
endtask

initial begin
    Clock       = 1'b0;
    rstN        = 1'b0;
    imemWrEn    = 1'b0;
    imemWrAddr  = '0;
    imemWrData  = '0;
    dMemReady   = 1'b1;
    randomReady = 1'b0;
    seed        = 32'h15c2;
    errors      = 0;
    checks      = 0;
    nextStore   = 0;
    buildProgram();
    loadProgram();
    runProgram(1'b0);
    runProgram(1'b1); // Same store list under back-pressure
    $display("errors %0d in %0d checks", errors, checks);
    if (errors == 0) begin
        $display("ALL TESTS PASSED");
    end else begin
        $display("SOME TESTS FAILED");
    end
    $finish;
end

endmodule
